// File: verilog/stq_pkg.sv
package stq_pkg;

  // Queue shape defaults, overridden through stq_top parameters
  localparam int STQ_ENTRIES = 4;
  localparam int LRQ_ENTRIES = 4;

  localparam int CMT_ID_W = 5;  // Commit block id
  localparam int GRP_W    = 4;  // One bit per dispatch slot
  localparam int PADDR_W  = 32;
  localparam int DATA_W   = 32;

  // Per-entry store state
  typedef enum logic [2:0] {
    STQ_INIT             = 3'd0,  // Waiting for EX1
    STQ_TLB_HAZ          = 3'd1,
    STQ_READY            = 3'd2,  // Rerun requested
    STQ_DONE             = 3'd3,  // Waiting for commit
    STQ_COMMIT           = 3'd4,  // L1D request pending
    STQ_COMMIT_L1D_CHECK = 3'd5,
    STQ_WAIT_LRQ_REFILL  = 3'd6,
    STQ_L1D_UPDATE       = 3'd7
  } stq_state_e;

endpackage

// File: verilog/stq_alloc.sv
`timescale 1ns/100ps

module stq_alloc #(
  parameter int STQ_ENTRIES = stq_pkg::STQ_ENTRIES
) (
  input  logic                           i_disp_valid,
  input  logic [STQ_ENTRIES-1:0]         i_entry_valid,
  output logic [STQ_ENTRIES-1:0]         o_disp_load,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_disp_stq_idx,
  output logic                           o_disp_full
);

  localparam int IDX_W = $clog2(STQ_ENTRIES);

  logic [IDX_W-1:0] free_idx;
  logic             free_found;

  // Lowest free entry wins
  always_comb begin
    free_idx   = '0;
    free_found = 1'b0;
    for (int i = STQ_ENTRIES - 1; i >= 0; i--) begin
      if (!i_entry_valid[i]) begin
        free_idx   = IDX_W'(i);
        free_found = 1'b1;
      end
    end
  end

  assign o_disp_full    = ~free_found;
  assign o_disp_stq_idx = free_idx;

  always_comb begin
    o_disp_load = '0;
    if (i_disp_valid && free_found) begin
      o_disp_load[free_idx] = 1'b1;
    end
  end

endmodule

// File: verilog/stq_entry.sv
`timescale 1ns/100ps

module stq_entry #(
  parameter int LRQ_ENTRIES = stq_pkg::LRQ_ENTRIES
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_disp_load,
  input  logic [stq_pkg::CMT_ID_W-1:0] i_disp_cmt_id,
  input  logic [stq_pkg::GRP_W-1:0]    i_disp_grp_id,

  input  logic                         i_ex1_valid,  // Already decoded for this entry
  input  logic                         i_ex1_hazard,
  input  logic [stq_pkg::PADDR_W-1:0]  i_ex1_paddr,
  input  logic [stq_pkg::DATA_W-1:0]   i_ex1_data,

  input  logic                         i_tlb_resolve,
  input  logic                         i_rerun_accept,

  input  logic                         i_commit_valid,
  input  logic [stq_pkg::CMT_ID_W-1:0] i_commit_cmt_id,
  input  logic [stq_pkg::GRP_W-1:0]    i_commit_grp_id,

  input  logic                         i_req_accept,
  input  logic                         i_l1d_rd_miss,
  input  logic                         i_l1d_rd_conflict,
  input  logic [LRQ_ENTRIES-1:0]       i_l1d_lrq_idx_oh,
  input  logic                         i_l1d_wr_conflict,

  input  logic                         i_lrq_resolve_valid,
  input  logic [LRQ_ENTRIES-1:0]       i_lrq_resolve_idx_oh,

  output logic                         o_valid,
  output stq_pkg::stq_state_e          o_state,
  output logic [stq_pkg::PADDR_W-1:0]  o_paddr,
  output logic [stq_pkg::DATA_W-1:0]   o_data
);

  import stq_pkg::*;

  logic                   r_valid;
  stq_state_e             r_state;
  logic [CMT_ID_W-1:0]    r_cmt_id;
  logic [GRP_W-1:0]       r_grp_id;
  logic [PADDR_W-1:0]     r_paddr;
  logic [DATA_W-1:0]      r_data;
  logic [LRQ_ENTRIES-1:0] r_lrq_idx_oh;  // Refill slot we wait on

  logic w_ex1_upd;
  logic w_commit_hit;
  logic w_rd_miss;

  assign w_ex1_upd = r_valid && (r_state == STQ_INIT) && i_ex1_valid && !i_disp_load;
  assign w_commit_hit = i_commit_valid && (i_commit_cmt_id == r_cmt_id) &&
                        (|(i_commit_grp_id & r_grp_id));
  assign w_rd_miss = (r_state == STQ_COMMIT_L1D_CHECK) && i_l1d_rd_miss;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_state <= STQ_INIT;
    end else begin
      case (r_state)
        STQ_INIT: begin
          if (i_disp_load) begin
            r_valid <= 1'b1;
          end else if (w_ex1_upd) begin
            r_state <= i_ex1_hazard ? STQ_TLB_HAZ : STQ_DONE;
          end
        end
        STQ_TLB_HAZ: if (i_tlb_resolve) r_state <= STQ_READY;
        STQ_READY:   if (i_rerun_accept) r_state <= STQ_INIT;  // Valid stays set
        STQ_DONE:    if (w_commit_hit) r_state <= STQ_COMMIT;
        STQ_COMMIT:  if (i_req_accept) r_state <= STQ_COMMIT_L1D_CHECK;
        STQ_COMMIT_L1D_CHECK: begin
          if (i_l1d_rd_miss) begin
            r_state <= STQ_WAIT_LRQ_REFILL;
          end else if (i_l1d_rd_conflict) begin
            r_state <= STQ_COMMIT;  // Replay
          end else begin
            r_state <= STQ_L1D_UPDATE;
          end
        end
        STQ_WAIT_LRQ_REFILL: begin
          if (i_lrq_resolve_valid && (i_lrq_resolve_idx_oh == r_lrq_idx_oh)) begin
            r_state <= STQ_COMMIT;
          end
        end
        STQ_L1D_UPDATE: begin
          if (i_l1d_wr_conflict) begin
            r_state <= STQ_COMMIT;  // Replay
          end else begin
            r_state <= STQ_INIT;
            r_valid <= 1'b0;  // Written, slot free again
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_cmt_id <= i_disp_cmt_id;
      r_grp_id <= i_disp_grp_id;
    end
    if (w_ex1_upd) begin
      r_paddr <= i_ex1_paddr;
      r_data  <= i_ex1_data;
    end
    if (w_rd_miss) r_lrq_idx_oh <= i_l1d_lrq_idx_oh;
  end

  assign o_valid = r_valid;
  assign o_state = r_state;
  assign o_paddr = r_paddr;
  assign o_data  = r_data;

endmodule

// File: verilog/stq_issue_sel.sv
`timescale 1ns/100ps

module stq_issue_sel #(
  parameter int STQ_ENTRIES = stq_pkg::STQ_ENTRIES
) (
  input  stq_pkg::stq_state_e [STQ_ENTRIES-1:0]           i_state,
  input  logic [STQ_ENTRIES-1:0][stq_pkg::PADDR_W-1:0]    i_paddr,
  input  logic [STQ_ENTRIES-1:0][stq_pkg::DATA_W-1:0]     i_data,

  input  logic                                            i_rerun_accept,
  input  logic                                            i_l1d_req_accept,
  input  logic                                            i_l1d_wr_conflict,

  output logic                                            o_rerun_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0]                  o_rerun_idx,
  output logic [STQ_ENTRIES-1:0]                          o_entry_rerun_accept,

  output logic                                            o_l1d_req_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0]                  o_l1d_req_idx,
  output logic [stq_pkg::PADDR_W-1:0]                     o_l1d_req_paddr,
  output logic [stq_pkg::DATA_W-1:0]                      o_l1d_req_data,
  output logic [STQ_ENTRIES-1:0]                          o_entry_req_accept,

  output logic                                            o_store_done,
  output logic [stq_pkg::PADDR_W-1:0]                     o_store_done_paddr,
  output logic [stq_pkg::DATA_W-1:0]                      o_store_done_data
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_ENTRIES);

  logic [IDX_W-1:0] upd_idx;
  logic             upd_found;

  // Scan from the top so the lowest match is left standing
  always_comb begin
    o_rerun_valid   = 1'b0;
    o_rerun_idx     = '0;
    o_l1d_req_valid = 1'b0;
    o_l1d_req_idx   = '0;
    upd_found       = 1'b0;
    upd_idx         = '0;
    for (int i = STQ_ENTRIES - 1; i >= 0; i--) begin
      if (i_state[i] == STQ_READY) begin
        o_rerun_valid = 1'b1;
        o_rerun_idx   = IDX_W'(i);
      end
      if (i_state[i] == STQ_COMMIT) begin
        o_l1d_req_valid = 1'b1;
        o_l1d_req_idx   = IDX_W'(i);
      end
      if (i_state[i] == STQ_L1D_UPDATE) begin  // At most one
        upd_found = 1'b1;
        upd_idx   = IDX_W'(i);
      end
    end
  end

  assign o_l1d_req_paddr = i_paddr[o_l1d_req_idx];
  assign o_l1d_req_data  = i_data[o_l1d_req_idx];

  always_comb begin
    o_entry_rerun_accept = '0;
    o_entry_req_accept   = '0;
    if (o_rerun_valid && i_rerun_accept) o_entry_rerun_accept[o_rerun_idx] = 1'b1;
    if (o_l1d_req_valid && i_l1d_req_accept) o_entry_req_accept[o_l1d_req_idx] = 1'b1;
  end

  assign o_store_done       = upd_found && !i_l1d_wr_conflict;
  assign o_store_done_paddr = i_paddr[upd_idx];
  assign o_store_done_data  = i_data[upd_idx];

endmodule

// File: verilog/stq_top.sv
`timescale 1ns/100ps

module stq_top #(
  parameter int STQ_ENTRIES = stq_pkg::STQ_ENTRIES,
  parameter int LRQ_ENTRIES = stq_pkg::LRQ_ENTRIES
) (
  input  logic                           i_clk,
  input  logic                           i_reset_n,

  input  logic                           i_disp_valid,
  input  logic [stq_pkg::CMT_ID_W-1:0]   i_disp_cmt_id,
  input  logic [stq_pkg::GRP_W-1:0]      i_disp_grp_id,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_disp_stq_idx,
  output logic                           o_disp_full,

  input  logic                           i_ex1_valid,
  input  logic [$clog2(STQ_ENTRIES)-1:0] i_ex1_stq_idx,
  input  logic                           i_ex1_hazard,
  input  logic [stq_pkg::PADDR_W-1:0]    i_ex1_paddr,
  input  logic [stq_pkg::DATA_W-1:0]     i_ex1_data,

  input  logic                           i_tlb_resolve,

  input  logic                           i_rerun_accept,
  output logic                           o_rerun_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_rerun_idx,

  input  logic                           i_commit_valid,
  input  logic [stq_pkg::CMT_ID_W-1:0]   i_commit_cmt_id,
  input  logic [stq_pkg::GRP_W-1:0]      i_commit_grp_id,

  input  logic                           i_l1d_req_accept,
  output logic                           o_l1d_req_valid,
  output logic [$clog2(STQ_ENTRIES)-1:0] o_l1d_req_idx,
  output logic [stq_pkg::PADDR_W-1:0]    o_l1d_req_paddr,
  output logic [stq_pkg::DATA_W-1:0]     o_l1d_req_data,

  input  logic                           i_l1d_rd_miss,
  input  logic                           i_l1d_rd_conflict,
  input  logic [LRQ_ENTRIES-1:0]         i_l1d_lrq_idx_oh,
  input  logic                           i_l1d_wr_conflict,

  input  logic                           i_lrq_resolve_valid,
  input  logic [LRQ_ENTRIES-1:0]         i_lrq_resolve_idx_oh,

  output logic                           o_store_done,
  output logic [stq_pkg::PADDR_W-1:0]    o_store_done_paddr,
  output logic [stq_pkg::DATA_W-1:0]     o_store_done_data
);

  import stq_pkg::*;

  localparam int IDX_W = $clog2(STQ_ENTRIES);

  logic [STQ_ENTRIES-1:0]              w_disp_load;
  logic [STQ_ENTRIES-1:0]              w_ex1_valid;
  logic [STQ_ENTRIES-1:0]              w_rerun_accept;
  logic [STQ_ENTRIES-1:0]              w_req_accept;
  logic [STQ_ENTRIES-1:0]              w_valid;
  stq_state_e [STQ_ENTRIES-1:0]        w_state;
  logic [STQ_ENTRIES-1:0][PADDR_W-1:0] w_paddr;
  logic [STQ_ENTRIES-1:0][DATA_W-1:0]  w_data;

  stq_alloc #(
    .STQ_ENTRIES (STQ_ENTRIES)
  ) u_alloc (
    .i_disp_valid   (i_disp_valid),
    .i_entry_valid  (w_valid),
    .o_disp_load    (w_disp_load),
    .o_disp_stq_idx (o_disp_stq_idx),
    .o_disp_full    (o_disp_full)
  );

  for (genvar g = 0; g < STQ_ENTRIES; g++) begin : g_entry
    assign w_ex1_valid[g] = i_ex1_valid && (i_ex1_stq_idx == IDX_W'(g));

    stq_entry #(
      .LRQ_ENTRIES (LRQ_ENTRIES)
    ) u_entry (
      .i_clk                (i_clk),
      .i_reset_n            (i_reset_n),
      .i_disp_load          (w_disp_load[g]),
      .i_disp_cmt_id        (i_disp_cmt_id),
      .i_disp_grp_id        (i_disp_grp_id),
      .i_ex1_valid          (w_ex1_valid[g]),
      .i_ex1_hazard         (i_ex1_hazard),
      .i_ex1_paddr          (i_ex1_paddr),
      .i_ex1_data           (i_ex1_data),
      .i_tlb_resolve        (i_tlb_resolve),
      .i_rerun_accept       (w_rerun_accept[g]),
      .i_commit_valid       (i_commit_valid),
      .i_commit_cmt_id      (i_commit_cmt_id),
      .i_commit_grp_id      (i_commit_grp_id),
      .i_req_accept         (w_req_accept[g]),
      .i_l1d_rd_miss        (i_l1d_rd_miss),  // Only the entry in check reacts
      .i_l1d_rd_conflict    (i_l1d_rd_conflict),
      .i_l1d_lrq_idx_oh     (i_l1d_lrq_idx_oh),
      .i_l1d_wr_conflict    (i_l1d_wr_conflict),
      .i_lrq_resolve_valid  (i_lrq_resolve_valid),
      .i_lrq_resolve_idx_oh (i_lrq_resolve_idx_oh),
      .o_valid              (w_valid[g]),
      .o_state              (w_state[g]),
      .o_paddr              (w_paddr[g]),
      .o_data               (w_data[g])
    );
  end

  stq_issue_sel #(
    .STQ_ENTRIES (STQ_ENTRIES)
  ) u_issue_sel (
    .i_state              (w_state),
    .i_paddr              (w_paddr),
    .i_data               (w_data),
    .i_rerun_accept       (i_rerun_accept),
    .i_l1d_req_accept     (i_l1d_req_accept),
    .i_l1d_wr_conflict    (i_l1d_wr_conflict),
    .o_rerun_valid        (o_rerun_valid),
    .o_rerun_idx          (o_rerun_idx),
    .o_entry_rerun_accept (w_rerun_accept),
    .o_l1d_req_valid      (o_l1d_req_valid),
    .o_l1d_req_idx        (o_l1d_req_idx),
    .o_l1d_req_paddr      (o_l1d_req_paddr),
    .o_l1d_req_data       (o_l1d_req_data),
    .o_entry_req_accept   (w_req_accept),
    .o_store_done         (o_store_done),
    .o_store_done_paddr   (o_store_done_paddr),
    .o_store_done_data    (o_store_done_data)
  );

endmodule

// File: test/tb_stq.sv
`timescale 1ns/100ps

module tb_stq;

  import stq_pkg::*;

  localparam int STQ_N      = 4;
  localparam int LRQ_N      = 4;
  localparam int IDX_W      = $clog2(STQ_N);
  localparam int RUN_CYCLES = 2000;
  localparam int MAX_CYCLES = 2 * RUN_CYCLES;  // Random run plus a generous drain

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  logic [CMT_ID_W-1:0] i_disp_cmt_id;
  logic [GRP_W-1:0]    i_disp_grp_id;
  logic                i_ex1_valid;
  logic [IDX_W-1:0]    i_ex1_stq_idx;
  logic                i_ex1_hazard;
  logic [PADDR_W-1:0]  i_ex1_paddr;
  logic [DATA_W-1:0]   i_ex1_data;
  logic                i_tlb_resolve;
  logic                i_rerun_accept;
  logic                i_commit_valid;
  logic [CMT_ID_W-1:0] i_commit_cmt_id;
  logic [GRP_W-1:0]    i_commit_grp_id;
  logic                i_l1d_req_accept;
  logic                i_l1d_rd_miss;
  logic                i_l1d_rd_conflict;
  logic [LRQ_N-1:0]    i_l1d_lrq_idx_oh;
  logic                i_l1d_wr_conflict;
  logic                i_lrq_resolve_valid;
  logic [LRQ_N-1:0]    i_lrq_resolve_idx_oh;

  logic [IDX_W-1:0]    o_disp_stq_idx;
  logic                o_disp_full;
  logic                o_rerun_valid;
  logic [IDX_W-1:0]    o_rerun_idx;
  logic                o_l1d_req_valid;
  logic [IDX_W-1:0]    o_l1d_req_idx;
  logic [PADDR_W-1:0]  o_l1d_req_paddr;
  logic [DATA_W-1:0]   o_l1d_req_data;
  logic                o_store_done;
  logic [PADDR_W-1:0]  o_store_done_paddr;
  logic [DATA_W-1:0]   o_store_done_data;

  // Reference model of the queue
  logic                m_valid [STQ_N];
  stq_state_e          m_state [STQ_N];
  logic [CMT_ID_W-1:0] m_cmt   [STQ_N];
  logic [GRP_W-1:0]    m_grp   [STQ_N];
  logic [PADDR_W-1:0]  m_paddr [STQ_N];
  logic [DATA_W-1:0]   m_data  [STQ_N];
  logic [LRQ_N-1:0]    m_lrq   [STQ_N];  // LRQ slot recorded at a read miss

  integer seed = 18947;
  int     n_disp;
  int     n_done;  // Store-done pulses seen on the DUT
  int     cycle_cnt = 0;

  stq_top #(
    .STQ_ENTRIES (STQ_N),
    .LRQ_ENTRIES (LRQ_N)
  ) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the queue did not drain within %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

  function automatic int unsigned rand_below(int unsigned n);
    rand_below = $unsigned($random(seed)) % n;
  endfunction

  function automatic bit one_in(int unsigned n);
    one_in = (rand_below(n) == 0);
  endfunction

  function automatic int lowest_in(stq_state_e s);
    int i;
    lowest_in = -1;
    for (i = STQ_N - 1; i >= 0; i--) begin
      if (m_state[i] == s) lowest_in = i;
    end
  endfunction

  function automatic int lowest_free();
    int i;
    lowest_free = -1;
    for (i = STQ_N - 1; i >= 0; i--) begin
      if (!m_valid[i]) lowest_free = i;
    end
  endfunction

  function automatic bit model_empty();
    int i;
    model_empty = 1'b1;
    for (i = 0; i < STQ_N; i++) begin
      if (m_valid[i]) model_empty = 1'b0;
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic clear_inputs();
    i_disp_valid         = 1'b0;
    i_disp_cmt_id        = '0;
    i_disp_grp_id        = '0;
    i_ex1_valid          = 1'b0;
    i_ex1_stq_idx        = '0;
    i_ex1_hazard         = 1'b0;
    i_ex1_paddr          = '0;
    i_ex1_data           = '0;
    i_tlb_resolve        = 1'b0;
    i_rerun_accept       = 1'b0;
    i_commit_valid       = 1'b0;
    i_commit_cmt_id      = '0;
    i_commit_grp_id      = '0;
    i_l1d_req_accept     = 1'b0;
    i_l1d_rd_miss        = 1'b0;
    i_l1d_rd_conflict    = 1'b0;
    i_l1d_lrq_idx_oh     = '0;
    i_l1d_wr_conflict    = 1'b0;
    i_lrq_resolve_valid  = 1'b0;
    i_lrq_resolve_idx_oh = '0;
  endtask

  task automatic drive_inputs(input bit allow_disp);
    int cand[$];
    int i;
    int pick;
    cand = {};
    i_disp_valid  = allow_disp && (lowest_free() >= 0) && one_in(2);
    i_disp_cmt_id = CMT_ID_W'(rand_below(4));
    i_disp_grp_id = GRP_W'(rand_below(15) + 1);  // Nonzero so the store can commit
    // EX1 only targets stores still waiting for their address
    for (i = 0; i < STQ_N; i++) begin
      if (m_valid[i] && m_state[i] == STQ_INIT) cand.push_back(i);
    end
    i_ex1_valid = 1'b0;
    if (cand.size() > 0 && one_in(2)) begin
      pick          = cand[rand_below(cand.size())];
      i_ex1_valid   = 1'b1;
      i_ex1_stq_idx = IDX_W'(pick);
    end
    i_ex1_hazard         = one_in(3);
    i_ex1_paddr          = $random(seed);
    i_ex1_data           = $random(seed);
    i_tlb_resolve        = one_in(4);
    i_rerun_accept       = one_in(2);
    i_commit_valid       = one_in(2);
    i_commit_cmt_id      = CMT_ID_W'(rand_below(4));
    i_commit_grp_id      = GRP_W'(rand_below(16));
    i_l1d_req_accept     = one_in(2);
    i_l1d_rd_miss        = one_in(4);
    i_l1d_rd_conflict    = one_in(4);
    i_l1d_lrq_idx_oh     = LRQ_N'(1 << rand_below(LRQ_N));
    i_l1d_wr_conflict    = one_in(4);
    i_lrq_resolve_valid  = one_in(4);
    i_lrq_resolve_idx_oh = LRQ_N'(1 << rand_below(LRQ_N));
  endtask

  task automatic check_outputs();
    int free_idx;
    int ready_idx;
    int commit_idx;
    int upd_idx;
    bit exp_done;
    free_idx   = lowest_free();
    ready_idx  = lowest_in(STQ_READY);
    commit_idx = lowest_in(STQ_COMMIT);
    upd_idx    = lowest_in(STQ_L1D_UPDATE);
    exp_done   = (upd_idx >= 0) && !i_l1d_wr_conflict;
    check_value("o_disp_full", 32'(o_disp_full), 32'(free_idx < 0));
    if (free_idx >= 0) check_value("o_disp_stq_idx", 32'(o_disp_stq_idx), 32'(free_idx));
    check_value("o_rerun_valid", 32'(o_rerun_valid), 32'(ready_idx >= 0));
    if (ready_idx >= 0) check_value("o_rerun_idx", 32'(o_rerun_idx), 32'(ready_idx));
    check_value("o_l1d_req_valid", 32'(o_l1d_req_valid), 32'(commit_idx >= 0));
    if (commit_idx >= 0) begin
      check_value("o_l1d_req_idx", 32'(o_l1d_req_idx), 32'(commit_idx));
      check_value("o_l1d_req_paddr", o_l1d_req_paddr, m_paddr[commit_idx]);
      check_value("o_l1d_req_data", o_l1d_req_data, m_data[commit_idx]);
    end
    check_value("o_store_done", 32'(o_store_done), 32'(exp_done));
    if (exp_done) begin
      check_value("o_store_done_paddr", o_store_done_paddr, m_paddr[upd_idx]);
      check_value("o_store_done_data", o_store_done_data, m_data[upd_idx]);
    end
  endtask

  // Applies the entry transition rules at a rising edge
  task automatic update_model();
    int i;
    int ready_idx;
    int commit_idx;
    int free_idx;
    ready_idx  = lowest_in(STQ_READY);
    commit_idx = lowest_in(STQ_COMMIT);
    free_idx   = lowest_free();
    for (i = 0; i < STQ_N; i++) begin
      case (m_state[i])
        STQ_INIT: begin
          if (i_disp_valid && i == free_idx) begin
            m_valid[i] = 1'b1;
            m_cmt[i]   = i_disp_cmt_id;
            m_grp[i]   = i_disp_grp_id;
            n_disp++;
          end else if (m_valid[i] && i_ex1_valid && int'(i_ex1_stq_idx) == i) begin
            m_state[i] = i_ex1_hazard ? STQ_TLB_HAZ : STQ_DONE;
            m_paddr[i] = i_ex1_paddr;
            m_data[i]  = i_ex1_data;
          end
        end
        STQ_TLB_HAZ: if (i_tlb_resolve) m_state[i] = STQ_READY;
        STQ_READY:   if (i_rerun_accept && i == ready_idx) m_state[i] = STQ_INIT;
        STQ_DONE: begin
          if (i_commit_valid && i_commit_cmt_id == m_cmt[i] &&
              (i_commit_grp_id & m_grp[i]) != '0) begin
            m_state[i] = STQ_COMMIT;
          end
        end
        STQ_COMMIT: if (i_l1d_req_accept && i == commit_idx) m_state[i] = STQ_COMMIT_L1D_CHECK;
        STQ_COMMIT_L1D_CHECK: begin
          if (i_l1d_rd_miss) begin
            m_state[i] = STQ_WAIT_LRQ_REFILL;
            m_lrq[i]   = i_l1d_lrq_idx_oh;
          end else if (i_l1d_rd_conflict) begin
            m_state[i] = STQ_COMMIT;
          end else begin
            m_state[i] = STQ_L1D_UPDATE;
          end
        end
        STQ_WAIT_LRQ_REFILL: begin
          if (i_lrq_resolve_valid && i_lrq_resolve_idx_oh == m_lrq[i]) m_state[i] = STQ_COMMIT;
        end
        STQ_L1D_UPDATE: begin
          if (i_l1d_wr_conflict) begin
            m_state[i] = STQ_COMMIT;
          end else begin
            m_state[i] = STQ_INIT;
            m_valid[i] = 1'b0;
          end
        end
      endcase
    end
  endtask

  task automatic run_cycle(input bit allow_disp);
    @(negedge i_clk);
    drive_inputs(allow_disp);
    #10;
    check_outputs();
    if (o_store_done === 1'b1) n_done++;
    @(posedge i_clk);
    update_model();
  endtask

  initial begin
    int i;
    int k;
    clear_inputs();
    i_reset_n = 1'b0;
    n_disp    = 0;
    n_done    = 0;
    for (i = 0; i < STQ_N; i++) begin
      m_valid[i] = 1'b0;
      m_state[i] = STQ_INIT;
    end
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    check_outputs();  // Still in reset
    i_reset_n = 1'b1;
    for (k = 0; k < RUN_CYCLES; k++) begin
      run_cycle(1'b1);
    end
    while (!model_empty()) begin
      run_cycle(1'b0);
    end
    check_value("stores completed", 32'(n_done), 32'(n_disp));
    $display("%0d stores dispatched and completed", n_done);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: tb.f
verilog/stq_pkg.sv
verilog/stq_alloc.sv
verilog/stq_entry.sv
verilog/stq_issue_sel.sv
verilog/stq_top.sv
test/tb_stq.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_stq -f tb.f

# The log decides the result, so a failing run must not stop the script here
./obj_dir/Vtb_stq > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
